//--- bench/tb_pakout_io.sv
`timescale 1ns/100ps

module tb_pakout_io import pak_pkg::*; ();

	localparam int OUT_PAKS = 40;
	localparam int TIMEOUT_CYCLES = 3000;

	logic i_clk;
	logic reset;
	packet_t o0_pak;
	logic o0_req;
	logic o0_ack;
	packet_t i0_pak;
	logic i0_req;
	logic i0_ack;
	logic [3:0] dbg_case;
	dbg_t dbg;

	int errors = 0;
	int cycles = 0;
	int out_done = 0;
	int got_idx = 0;
	int ack_pulses = 0;
	logic [31:0] lcg_state = 32'd62;
	logic o0_req_d = 1'b0;
	logic i0_ack_d = 1'b0;
	// Outbound packets taken by the peer, and inbound ones sent since reset
	packet_t got_q[$];
	packet_t sent_q[$];

	pakout_io DUT (
		.i_clk    (i_clk),
		.reset    (reset),
		.o0_pak   (o0_pak),
		.o0_req   (o0_req),
		.o0_ack   (o0_ack),
		.i0_pak   (i0_pak),
		.i0_req   (i0_req),
		.i0_ack   (i0_ack),
		.dbg_case (dbg_case),
		.dbg      (dbg)
	);

	initial i_clk = 1'b0;
	always #20 i_clk = ~i_clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [RSZ-1:0] ref_red(input packet_t p);
		return p.src[7:4] ^ p.src[3:0] ^ p.dst[7:4] ^ p.dst[3:0] ^ p.dat[7:4] ^ p.dat[3:0];
	endfunction

	function automatic packet_t make_pak(input int src, input int dst, input int dat);
		packet_t p;
		p.src = ASZ'(src);
		p.dst = ASZ'(dst);
		p.dat = DSZ'(dat);
		p.red = '0;
		p.red = ref_red(p);
		return p;
	endfunction

	// Expected outbound packet number n
	function automatic packet_t ref_out_pak(input int n);
		return make_pak(SRC_ADDR, MIN_ADDR + n % (MAX_ADDR - MIN_ADDR + 1), n % 256);
	endfunction

	// Expected sink view after the given inbound packets
	function automatic dbg_t ref_sink_view(input packet_t paks[$]);
		dbg_t v;
		logic [DSZ-1:0] prev;
		v = '0;
		prev = '0;
		foreach (paks[i]) begin
			v.leds[0] = 1'b1;
			if (paks[i].src != ASZ'(SRC_ADDR)) begin
				if (!v.leds[1])
					v.disp0 = paks[i].src[3:0];
				v.leds[1] = 1'b1;
			end
			if (i > 0 && paks[i].dat != prev + 8'd1) begin
				if (!v.leds[2])
					v.disp1 = paks[i].dst[3:0];
				v.leds[2] = 1'b1;
			end
			if (paks[i].red != ref_red(paks[i]))
				v.leds[3] = 1'b1;
			prev = paks[i].dat;
		end
		return v;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic apply_reset();
		reset <= 1'b1;
		repeat (10) @(negedge i_clk);
		reset <= 1'b0;
		sent_q.delete();
	endtask

	// Four-phase send on i0, starts and ends on a falling edge
	task automatic send_in(input packet_t p);
		i0_pak <= p;
		i0_req <= 1'b1;
		do @(negedge i_clk); while (!i0_ack);
		i0_req <= 1'b0;
		do @(negedge i_clk); while (i0_ack);
		sent_q.push_back(p);
	endtask

	task automatic check_sink(input string tag);
		dbg_t exp_v;
		exp_v = ref_sink_view(sent_q);
		repeat (4) @(negedge i_clk);
		check_val({tag, " dbg.leds"}, 32'(dbg.leds), 32'(exp_v.leds));
		check_val({tag, " dbg.disp0"}, 32'(dbg.disp0), 32'(exp_v.disp0));
		check_val({tag, " dbg.disp1"}, 32'(dbg.disp1), 32'(exp_v.disp1));
	endtask

	// o0 peer, acks the first OUT_PAKS packets after a random delay
	initial begin : out_peer
		int delay;
		forever begin
			@(negedge i_clk);
			if (!reset && o0_req && !o0_ack && out_done < OUT_PAKS) begin
				lcg_state = lcg_next(lcg_state);
				delay = int'(lcg_state[17:16]);
				repeat (delay) @(negedge i_clk);
				got_q.push_back(o0_pak);
				o0_ack <= 1'b1;
				do @(negedge i_clk); while (o0_req);
				// Ack held for a random time after req drops
				lcg_state = lcg_next(lcg_state);
				delay = int'(lcg_state[17:16]);
				repeat (delay) @(negedge i_clk);
				o0_ack <= 1'b0;
				out_done++;
			end
		end
	end

	always @(negedge i_clk) begin : compare_out
		packet_t got;
		packet_t exp_p;
		while (got_q.size() > 0) begin
			got = got_q.pop_front();
			exp_p = ref_out_pak(got_idx);
			check_val("o0_pak.src", 32'(got.src), 32'(exp_p.src));
			check_val("o0_pak.dst", 32'(got.dst), 32'(exp_p.dst));
			check_val("o0_pak.dat", 32'(got.dat), 32'(exp_p.dat));
			check_val("o0_pak.red", 32'(got.red), 32'(exp_p.red));
			got_idx++;
		end
	end

	// Handshake monitor for both channels
	always @(negedge i_clk) begin
		if (!reset) begin
			assert (!(o0_req && !o0_req_d && o0_ack)) else begin
				errors++;
				$display("Outbound req was raised while ack was still high");
			end
		end
		if (i0_ack && !i0_ack_d)
			ack_pulses++;
		o0_req_d = o0_req;
		i0_ack_d = i0_ack;
	end

	always @(posedge i_clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the test did not finish", cycles);
			$display("Errors: %0d", errors);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		int base;
		packet_t last_exp;
		reset = 1'b1;
		o0_ack = 1'b0;
		i0_pak = '0;
		i0_req = 1'b0;
		dbg_case = 4'd0;
		repeat (10) @(negedge i_clk);
		reset <= 1'b0;

		// Outbound stream and source view
		while (out_done < OUT_PAKS)
			@(negedge i_clk);
		repeat (3) @(negedge i_clk);
		last_exp = ref_out_pak(OUT_PAKS - 1);
		check_val("outbound packet count", 32'(got_idx), 32'(OUT_PAKS));
		check_val("src view dbg.leds", 32'(dbg.leds), 32'(OUT_PAKS % 16));
		check_val("src view dbg.disp0", 32'(dbg.disp0), 32'(last_exp.dst[3:0]));
		check_val("src view dbg.disp1", 32'(dbg.disp1), 32'(last_exp.dat[3:0]));

		// Clean inbound stream on the sink view
		dbg_case <= 4'd4;
		for (int k = 0; k < 20; k++)
			send_in(make_pak(SRC_ADDR, MIN_ADDR + k % 4, k));
		check_sink("good stream");

		// First offenders recorded, later ones ignored
		apply_reset();
		send_in(make_pak(SRC_ADDR, 1, 0));
		send_in(make_pak(9, 1, 1));
		send_in(make_pak(SRC_ADDR, 3, 2));
		send_in(make_pak(SRC_ADDR, 2, 7));
		send_in(make_pak(5, 3, 8));
		send_in(make_pak(SRC_ADDR, 4, 20));
		check_sink("first offender");

		// Corrupted redundancy nibble
		begin
			packet_t bad;
			bad = make_pak(SRC_ADDR, 1, 21);
			bad.red = bad.red ^ 4'h5;
			send_in(bad);
		end
		check_sink("bad red");

		// Back to back packets, none lost or doubled
		apply_reset();
		base = ack_pulses;
		for (int k = 0; k < 8; k++)
			send_in(make_pak(SRC_ADDR, MIN_ADDR + k % 4, 100 + k));
		check_sink("back-pressure");
		check_val("i0_ack pulse count", 32'(ack_pulses - base), 32'd8);

		repeat (2) @(negedge i_clk);
		$display("Errors: %0d, outbound packets checked: %0d", errors, got_idx);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- build.f
source/pak_pkg.sv
source/pak_source.sv
source/pak_fifo.sv
source/pak_receiver.sv
source/pak_checker.sv
source/dbg_select.sv
source/pakout_io.sv
bench/tb_pakout_io.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, all output goes to sim.log

verilator --binary --timing --assert -f build.f --top-module tb_pakout_io \
	-o sim_tb > sim.log 2>&1 \
	&& ./obj_dir/sim_tb >> sim.log 2>&1 \
	|| { cat sim.log; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "^=== PASS ===$" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- source/dbg_select.sv
`timescale 1ns/100ps

module dbg_select import pak_pkg::*; (
	input  logic       i_clk,
	input  logic       reset,
	input  logic [3:0] dbg_case,
	input  logic [3:0] sent_cnt,
	input  packet_t    last_pak,
	input  logic [3:0] err_flags,
	input  logic [3:0] info_src,
	input  logic [3:0] info_dst,
	output dbg_t       dbg
);

	dbg_t src_view;
	dbg_t snk_view;

	// Source view, packets sent and the last one's dst and dat
	always_comb begin
		src_view.leds = sent_cnt;
		src_view.disp0 = last_pak.dst[3:0];
		src_view.disp1 = last_pak.dat[3:0];
	end

	// Sink view, error flags and first-offender info
	always_comb begin
		snk_view.leds = err_flags;
		snk_view.disp0 = info_src;
		snk_view.disp1 = info_dst;
	end

	always_ff @(posedge i_clk) begin
		if (reset) begin
			dbg <= '0;
		end else if (dbg_case < 4'(DBG_SRC_CASES)) begin
			dbg <= src_view;
		end else begin
			dbg <= snk_view;
		end
	end

endmodule

//--- source/pak_checker.sv
`timescale 1ns/100ps

module pak_checker import pak_pkg::*; (
	input  logic       i_clk,
	input  logic       reset,
	output logic       pop,
	input  packet_t    pop_pak,
	input  logic       empty,
	output logic [3:0] err_flags,
	output logic [3:0] info_src,
	output logic [3:0] info_dst
);

	logic [DSZ-1:0] prev_dat;
	logic prev_valid;
	logic [DSZ-1:0] dat_expect;
	logic src_bad;
	logic seq_bad;
	logic red_bad;

	// Take one packet per cycle whenever one is waiting
	assign pop = !empty;

	assign dat_expect = prev_dat + 1'b1;

	assign src_bad = (pop_pak.src != ASZ'(SRC_ADDR));
	assign seq_bad = prev_valid && (pop_pak.dat != dat_expect);
	assign red_bad = (pop_pak.red != redun(pop_pak.src, pop_pak.dst, pop_pak.dat));

	// Sticky flags: received, src, sequence, redundancy
	always_ff @(posedge i_clk) begin
		if (reset) begin
			err_flags <= '0;
		end else if (pop) begin
			err_flags[0] <= 1'b1;
			if (src_bad)
				err_flags[1] <= 1'b1;
			if (seq_bad)
				err_flags[2] <= 1'b1;
			if (red_bad)
				err_flags[3] <= 1'b1;
		end
	end

	// Sequence tracking follows every packet, good or bad
	always_ff @(posedge i_clk) begin
		if (reset) begin
			prev_valid <= 1'b0;
		end else if (pop) begin
			prev_valid <= 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (pop)
			prev_dat <= pop_pak.dat;
	end

	// Only the first offender of each kind is recorded
	always_ff @(posedge i_clk) begin
		if (reset) begin
			info_src <= '0;
		end else if (pop && src_bad && !err_flags[1]) begin
			info_src <= pop_pak.src[3:0];
		end
	end

	always_ff @(posedge i_clk) begin
		if (reset) begin
			info_dst <= '0;
		end else if (pop && seq_bad && !err_flags[2]) begin
			info_dst <= pop_pak.dst[3:0];
		end
	end

endmodule

//--- source/pak_fifo.sv
`timescale 1ns/100ps

module pak_fifo import pak_pkg::*; (
	input  logic    i_clk,
	input  logic    reset,
	input  logic    push,
	input  packet_t push_pak,
	output logic    full,
	input  logic    pop,
	output packet_t pop_pak,
	output logic    empty
);

	packet_t mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	// One extra bit so a full FIFO is distinct from an empty one
	logic [FIFO_AW:0] count;

	assign full = (count == (FIFO_AW+1)'(FIFO_DEPTH));
	assign empty = (count == '0);

	// Head entry is visible without a pop
	assign pop_pak = mem[rd_ptr];

	always_ff @(posedge i_clk) begin
		if (push)
			mem[wr_ptr] <= push_pak;
	end

	always_ff @(posedge i_clk) begin
		if (reset) begin
			wr_ptr <= '0;
		end else if (push) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (reset) begin
			rd_ptr <= '0;
		end else if (pop) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- source/pak_pkg.sv
package pak_pkg;

	// Field sizes
	localparam int ASZ = 8;
	localparam int DSZ = 8;
	localparam int RSZ = 4;

	// Own address and the destination range walked by the source
	localparam int SRC_ADDR = 3;
	localparam int MIN_ADDR = 1;
	localparam int MAX_ADDR = 4;

	// Inbound buffering
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_AW = 2;

	// Debug cases below this value select the source view
	localparam int DBG_SRC_CASES = 4;

	typedef struct packed {
		logic [ASZ-1:0] src;
		logic [ASZ-1:0] dst;
		logic [DSZ-1:0] dat;
		logic [RSZ-1:0] red;
	} packet_t;

	typedef struct packed {
		logic [3:0] leds;
		logic [3:0] disp0;
		logic [3:0] disp1;
	} dbg_t;

	// Redundancy nibble, XOR of every nibble of the eight-bit fields
	function automatic logic [RSZ-1:0] redun(
		input logic [ASZ-1:0] src,
		input logic [ASZ-1:0] dst,
		input logic [DSZ-1:0] dat
	);
		logic [RSZ-1:0] acc;
		acc = src[7:4] ^ src[3:0];
		acc = acc ^ dst[7:4] ^ dst[3:0];
		acc = acc ^ dat[7:4] ^ dat[3:0];
		return acc;
	endfunction

endpackage

//--- source/pak_receiver.sv
`timescale 1ns/100ps

module pak_receiver import pak_pkg::*; (
	input  logic    i_clk,
	input  logic    reset,
	input  packet_t i0_pak,
	input  logic    i0_req,
	output logic    i0_ack,
	output logic    push,
	output packet_t push_pak,
	input  logic    full
);

	logic take;

	// New request, no ack outstanding and room in the FIFO
	assign take = i0_req && !i0_ack && !full;

	always_ff @(posedge i_clk) begin
		if (reset) begin
			i0_ack <= 1'b0;
		end else if (take) begin
			i0_ack <= 1'b1;
		end else if (!i0_req) begin
			// Sender has released req, finish the handshake
			i0_ack <= 1'b0;
		end
	end

	// One-cycle push, written into the FIFO on the following edge
	always_ff @(posedge i_clk) begin
		if (reset)
			push <= 1'b0;
		else
			push <= take;
	end

	always_ff @(posedge i_clk) begin
		if (take)
			push_pak <= i0_pak;
	end

endmodule

//--- source/pak_source.sv
`timescale 1ns/100ps

module pak_source import pak_pkg::*; (
	input  logic       i_clk,
	input  logic       reset,
	output packet_t    o0_pak,
	output logic       o0_req,
	input  logic       o0_ack,
	output logic [3:0] sent_cnt,
	output packet_t    last_pak
);

	typedef enum logic [1:0] {
		ST_LOAD,
		ST_REQ,
		ST_WAIT
	} state_t;

	state_t state;
	logic [ASZ-1:0] dst_nxt;
	logic [DSZ-1:0] dat_cnt;

	always_ff @(posedge i_clk) begin
		if (reset) begin
			state <= ST_LOAD;
			o0_req <= 1'b0;
			dst_nxt <= ASZ'(MIN_ADDR);
			dat_cnt <= '0;
			sent_cnt <= '0;
			last_pak <= '0;
		end else begin
			case (state)
				ST_LOAD: begin
					// Build the next packet while req is low
					o0_pak.src <= ASZ'(SRC_ADDR);
					o0_pak.dst <= dst_nxt;
					o0_pak.dat <= dat_cnt;
					o0_pak.red <= redun(ASZ'(SRC_ADDR), dst_nxt, dat_cnt);
					dat_cnt <= dat_cnt + 1'b1;
					if (dst_nxt >= ASZ'(MAX_ADDR))
						dst_nxt <= ASZ'(MIN_ADDR);
					else
						dst_nxt <= dst_nxt + 1'b1;
					state <= ST_REQ;
				end
				ST_REQ: begin
					// Peer must have released ack from the last packet
					if (!o0_ack) begin
						o0_req <= 1'b1;
						state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (o0_ack) begin
						o0_req <= 1'b0;
						sent_cnt <= sent_cnt + 1'b1;
						last_pak <= o0_pak;
						state <= ST_LOAD;
					end
				end
				default: state <= ST_LOAD;
			endcase
		end
	end

endmodule

//--- source/pakout_io.sv
`timescale 1ns/100ps

module pakout_io import pak_pkg::*; (
	input  logic       i_clk,
	input  logic       reset,

	// Outbound channel
	output packet_t    o0_pak,
	output logic       o0_req,
	input  logic       o0_ack,

	// Inbound channel
	input  packet_t    i0_pak,
	input  logic       i0_req,
	output logic       i0_ack,

	input  logic [3:0] dbg_case,
	output dbg_t       dbg
);

	// Source status
	logic [3:0] sent_cnt;
	packet_t last_pak;

	// Receiver to FIFO
	logic push;
	packet_t push_pak;
	logic full;

	// FIFO to checker
	logic pop;
	packet_t pop_pak;
	logic empty;

	// Sink status
	logic [3:0] err_flags;
	logic [3:0] info_src;
	logic [3:0] info_dst;

	pak_source u_source (
		.i_clk    (i_clk),
		.reset    (reset),
		.o0_pak   (o0_pak),
		.o0_req   (o0_req),
		.o0_ack   (o0_ack),
		.sent_cnt (sent_cnt),
		.last_pak (last_pak)
	);

	pak_receiver u_receiver (
		.i_clk    (i_clk),
		.reset    (reset),
		.i0_pak   (i0_pak),
		.i0_req   (i0_req),
		.i0_ack   (i0_ack),
		.push     (push),
		.push_pak (push_pak),
		.full     (full)
	);

	pak_fifo u_fifo (
		.i_clk    (i_clk),
		.reset    (reset),
		.push     (push),
		.push_pak (push_pak),
		.full     (full),
		.pop      (pop),
		.pop_pak  (pop_pak),
		.empty    (empty)
	);

	pak_checker u_checker (
		.i_clk     (i_clk),
		.reset     (reset),
		.pop       (pop),
		.pop_pak   (pop_pak),
		.empty     (empty),
		.err_flags (err_flags),
		.info_src  (info_src),
		.info_dst  (info_dst)
	);

	dbg_select u_dbg (
		.i_clk     (i_clk),
		.reset     (reset),
		.dbg_case  (dbg_case),
		.sent_cnt  (sent_cnt),
		.last_pak  (last_pak),
		.err_flags (err_flags),
		.info_src  (info_src),
		.info_dst  (info_dst),
		.dbg       (dbg)
	);

endmodule
